//--- cu_pkg.sv
`default_nettype none

package cu_pkg;

    // host control word and field widths
    typedef logic [31:0] ctrl_word_t;
    typedef logic [11:0] chan_cnt_t;
    typedef logic [8:0]  ofmap_dim_t;
    typedef logic [1:0]  op_t;

    // compute opcode, low byte of ctrl word 0
    localparam logic [7:0] INST_COMPUTE = 8'd87;

    localparam int MAC_NUM_DEFAULT = 256;

    // one-hot kernel size, bit n means (n+1)x(n+1)
    typedef enum logic [4:0] {
        k1 = 5'b00001,
        k2 = 5'b00010,
        k3 = 5'b00100,
        k4 = 5'b01000,
        k5 = 5'b10000
    } kernel_t;

    // input-map loader
    typedef enum logic [3:0] {
        ld_idle, ld_wait1, ld_load1, ld_wait2, ld_load2,
        ld_wait3, ld_load3, ld_wait4, ld_load4, ld_wait5, ld_load5,
        ld_compute, ld_wait_col, ld_load_col
    } ifmap_state_t;

    // weight read sequencer
    typedef enum logic [4:0] {
        wt_idle, wt_reset_addr,
        wt_k1_0,
        wt_k2_0, wt_k2_1,
        wt_k3_0, wt_k3_1, wt_k3_2,
        wt_k4_0, wt_k4_1, wt_k4_2, wt_k4_3,
        wt_k5_0, wt_k5_1, wt_k5_2, wt_k5_3, wt_k5_4,
        wt_k1_load, wt_k2_load, wt_k3_load, wt_k4_load, wt_k5_load
    } weight_state_t;

endpackage

`default_nettype wire

//--- cu_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface cu_cfg_if;

    logic                compute_active;
    cu_pkg::kernel_t     kernel_size;
    cu_pkg::chan_cnt_t   out_channels;
    cu_pkg::ofmap_dim_t  ofmap_width;

    // decoder side
    modport src (output compute_active, kernel_size, out_channels, ofmap_width);

    // sequencing modules
    modport dst (input compute_active, kernel_size, out_channels, ofmap_width);

    // observation only
    modport mon (input compute_active, kernel_size, out_channels, ofmap_width);

endinterface

`default_nettype wire

//--- instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder #(
    parameter int MAC_NUM = cu_pkg::MAC_NUM_DEFAULT
) (
    input  wire cu_pkg::ctrl_word_t ctrl_0,
    input  wire cu_pkg::ctrl_word_t ctrl_1,
    input  wire cu_pkg::ctrl_word_t ctrl_2,
    cu_cfg_if.src                   cfg,
    output cu_pkg::chan_cnt_t       in_channels,
    output cu_pkg::op_t             operation,
    output logic [MAC_NUM-1:0]      mac_enable
);

    logic [7:0] lane_limit;

    //////////////////////////////////////////////////
    // field extraction
    //////////////////////////////////////////////////

    // word 0: opcode, in channels, out channels
    assign cfg.compute_active = (ctrl_0[7:0] == cu_pkg::INST_COMPUTE);
    assign in_channels        = ctrl_0[19:8];
    assign cfg.out_channels   = ctrl_0[31:20];

    // word 1: op code and output map width
    assign operation          = ctrl_1[1:0];
    assign cfg.ofmap_width    = ctrl_1[10:2];

    // word 2: one-hot kernel size
    assign cfg.kernel_size    = cu_pkg::kernel_t'(ctrl_2[4:0]);

    //////////////////////////////////////////////////
    // mac lane mask
    //////////////////////////////////////////////////

    // only the low byte of the channel count selects lanes
    assign lane_limit = in_channels[7:0];

    always_comb begin
        for (int i = 0; i < MAC_NUM; i++) begin
            mac_enable[i] = (i < int'(lane_limit));
        end
    end

endmodule

`default_nettype wire

//--- ifmap_loader.sv
`timescale 1ns/1ps
`default_nettype none

module ifmap_loader (
    input  wire logic clk,
    input  wire logic rst_n,
    cu_cfg_if.dst     cfg,
    input  wire logic ifmap_fifo_empty,
    input  wire logic round_done,
    input  wire logic row_flush,
    input  wire logic layer_last,
    output logic      load_ifmaps,
    output logic      compute_phase,
    output logic      loader_idle
);

    cu_pkg::ifmap_state_t state;
    cu_pkg::ifmap_state_t state_nxt;

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            cu_pkg::ld_idle:  state_nxt = cu_pkg::ld_wait1;

            // row start, one column per wait/load pair up to k
            cu_pkg::ld_wait1: if (!ifmap_fifo_empty) state_nxt = cu_pkg::ld_load1;
            cu_pkg::ld_load1: state_nxt = (cfg.kernel_size == cu_pkg::k1) ?
                                          cu_pkg::ld_compute : cu_pkg::ld_wait2;
            cu_pkg::ld_wait2: if (!ifmap_fifo_empty) state_nxt = cu_pkg::ld_load2;
            cu_pkg::ld_load2: state_nxt = (cfg.kernel_size == cu_pkg::k2) ?
                                          cu_pkg::ld_compute : cu_pkg::ld_wait3;
            cu_pkg::ld_wait3: if (!ifmap_fifo_empty) state_nxt = cu_pkg::ld_load3;
            cu_pkg::ld_load3: state_nxt = (cfg.kernel_size == cu_pkg::k3) ?
                                          cu_pkg::ld_compute : cu_pkg::ld_wait4;
            cu_pkg::ld_wait4: if (!ifmap_fifo_empty) state_nxt = cu_pkg::ld_load4;
            cu_pkg::ld_load4: state_nxt = (cfg.kernel_size == cu_pkg::k4) ?
                                          cu_pkg::ld_compute : cu_pkg::ld_wait5;
            cu_pkg::ld_wait5: if (!ifmap_fifo_empty) state_nxt = cu_pkg::ld_load5;
            cu_pkg::ld_load5: state_nxt = cu_pkg::ld_compute;

            // hold until the weight round for this position is done
            cu_pkg::ld_compute: begin
                if (round_done) begin
                    if (layer_last) begin
                        state_nxt = cu_pkg::ld_idle;
                    end else if (row_flush) begin
                        state_nxt = cu_pkg::ld_wait1;
                    end else begin
                        state_nxt = cu_pkg::ld_wait_col;
                    end
                end
            end

            // next position in the row needs one new column
            cu_pkg::ld_wait_col: if (!ifmap_fifo_empty) state_nxt = cu_pkg::ld_load_col;
            cu_pkg::ld_load_col: state_nxt = cu_pkg::ld_compute;

            default: state_nxt = cu_pkg::ld_idle;
        endcase

        if (!cfg.compute_active) begin
            state_nxt = cu_pkg::ld_idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_pkg::ld_idle;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    // each load cycle pops one column from the fifo
    always_comb begin
        case (state)
            cu_pkg::ld_load1, cu_pkg::ld_load2, cu_pkg::ld_load3,
            cu_pkg::ld_load4, cu_pkg::ld_load5, cu_pkg::ld_load_col: load_ifmaps = 1'b1;
            default: load_ifmaps = 1'b0;
        endcase
    end

    assign compute_phase = (state == cu_pkg::ld_compute);
    assign loader_idle   = (state == cu_pkg::ld_idle);

endmodule

`default_nettype wire

//--- weight_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module weight_sequencer (
    input  wire logic clk,
    input  wire logic rst_n,
    cu_cfg_if.dst     cfg,
    input  wire logic compute_phase,
    input  wire logic weight_valid,
    output logic      load_weight_preload,
    output logic      load_weight,
    output logic      bram_port_sel,
    output logic      bram_transfer_start,
    output logic      round_done
);

    cu_pkg::weight_state_t state;
    cu_pkg::weight_state_t state_nxt;
    cu_pkg::chan_cnt_t     filter_cnt;
    cu_pkg::chan_cnt_t     filter_cnt_nxt;
    logic                  last_filter;
    logic                  mem_step;
    logic                  pass_step;
    logic                  load_state;

    assign filter_cnt_nxt = filter_cnt + cu_pkg::chan_cnt_t'(1);
    assign last_filter    = (filter_cnt_nxt == cfg.out_channels);

    //////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            cu_pkg::wt_idle: if (compute_phase) state_nxt = cu_pkg::wt_reset_addr;

            cu_pkg::wt_reset_addr: begin
                case (cfg.kernel_size)
                    cu_pkg::k2: state_nxt = cu_pkg::wt_k2_0;
                    cu_pkg::k3: state_nxt = cu_pkg::wt_k3_0;
                    cu_pkg::k4: state_nxt = cu_pkg::wt_k4_0;
                    cu_pkg::k5: state_nxt = cu_pkg::wt_k5_0;
                    default:    state_nxt = cu_pkg::wt_k1_0;
                endcase
            end

            // even steps read memory, odd steps use the other port
            cu_pkg::wt_k1_0: if (weight_valid) state_nxt = cu_pkg::wt_k1_load;

            cu_pkg::wt_k2_0: if (weight_valid) state_nxt = cu_pkg::wt_k2_1;
            cu_pkg::wt_k2_1: state_nxt = cu_pkg::wt_k2_load;

            cu_pkg::wt_k3_0: if (weight_valid) state_nxt = cu_pkg::wt_k3_1;
            cu_pkg::wt_k3_1: state_nxt = cu_pkg::wt_k3_2;
            cu_pkg::wt_k3_2: if (weight_valid) state_nxt = cu_pkg::wt_k3_load;

            cu_pkg::wt_k4_0: if (weight_valid) state_nxt = cu_pkg::wt_k4_1;
            cu_pkg::wt_k4_1: state_nxt = cu_pkg::wt_k4_2;
            cu_pkg::wt_k4_2: if (weight_valid) state_nxt = cu_pkg::wt_k4_3;
            cu_pkg::wt_k4_3: state_nxt = cu_pkg::wt_k4_load;

            cu_pkg::wt_k5_0: if (weight_valid) state_nxt = cu_pkg::wt_k5_1;
            cu_pkg::wt_k5_1: state_nxt = cu_pkg::wt_k5_2;
            cu_pkg::wt_k5_2: if (weight_valid) state_nxt = cu_pkg::wt_k5_3;
            cu_pkg::wt_k5_3: state_nxt = cu_pkg::wt_k5_4;
            cu_pkg::wt_k5_4: if (weight_valid) state_nxt = cu_pkg::wt_k5_load;

            // after the last filter the round ends
            cu_pkg::wt_k1_load: state_nxt = last_filter ? cu_pkg::wt_idle : cu_pkg::wt_k1_0;
            cu_pkg::wt_k2_load: state_nxt = last_filter ? cu_pkg::wt_idle : cu_pkg::wt_k2_0;
            cu_pkg::wt_k3_load: state_nxt = last_filter ? cu_pkg::wt_idle : cu_pkg::wt_k3_0;
            cu_pkg::wt_k4_load: state_nxt = last_filter ? cu_pkg::wt_idle : cu_pkg::wt_k4_0;
            cu_pkg::wt_k5_load: state_nxt = last_filter ? cu_pkg::wt_idle : cu_pkg::wt_k5_0;

            default: state_nxt = cu_pkg::wt_idle;
        endcase

        if (!cfg.compute_active) begin
            state_nxt = cu_pkg::wt_idle;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= cu_pkg::wt_idle;
        end else begin
            state <= state_nxt;
        end
    end

    //////////////////////////////////////////////////
    // filter counter
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            filter_cnt <= '0;
        end else if (state == cu_pkg::wt_idle) begin
            filter_cnt <= '0;
        end else if (load_state) begin
            filter_cnt <= filter_cnt_nxt;
        end
    end

    //////////////////////////////////////////////////
    // step decode and outputs
    //////////////////////////////////////////////////

    always_comb begin
        mem_step   = 1'b0;
        pass_step  = 1'b0;
        load_state = 1'b0;
        case (state)
            cu_pkg::wt_k1_0, cu_pkg::wt_k2_0, cu_pkg::wt_k3_0, cu_pkg::wt_k3_2,
            cu_pkg::wt_k4_0, cu_pkg::wt_k4_2, cu_pkg::wt_k5_0, cu_pkg::wt_k5_2,
            cu_pkg::wt_k5_4: mem_step = 1'b1;
            cu_pkg::wt_k2_1, cu_pkg::wt_k3_1, cu_pkg::wt_k4_1, cu_pkg::wt_k4_3,
            cu_pkg::wt_k5_1, cu_pkg::wt_k5_3: pass_step = 1'b1;
            cu_pkg::wt_k1_load, cu_pkg::wt_k2_load, cu_pkg::wt_k3_load,
            cu_pkg::wt_k4_load, cu_pkg::wt_k5_load: load_state = 1'b1;
            default: ;
        endcase
    end

    // memory steps preload only on the valid cycle
    assign load_weight_preload = (mem_step & weight_valid) | pass_step;
    assign bram_port_sel       = pass_step;
    assign load_weight         = load_state;
    assign bram_transfer_start = (state == cu_pkg::wt_reset_addr);
    assign round_done          = load_state & last_filter;

endmodule

`default_nettype wire

//--- ofmap_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module ofmap_tracker (
    input  wire logic clk,
    input  wire logic rst_n,
    cu_cfg_if.dst     cfg,
    input  wire logic loader_idle,
    input  wire logic round_done,
    output logic      row_flush,
    output logic      layer_last
);

    cu_pkg::ofmap_dim_t col_cnt;
    cu_pkg::ofmap_dim_t row_cnt;
    cu_pkg::ofmap_dim_t width_m1;

    assign width_m1 = cfg.ofmap_width - cu_pkg::ofmap_dim_t'(1);

    //////////////////////////////////////////////////
    // position counters
    //////////////////////////////////////////////////

    // square output map, rows counted on each column wrap
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (loader_idle) begin
            col_cnt <= '0;
            row_cnt <= '0;
        end else if (round_done) begin
            if (row_flush) begin
                col_cnt <= '0;
                row_cnt <= row_cnt + cu_pkg::ofmap_dim_t'(1);
            end else begin
                col_cnt <= col_cnt + cu_pkg::ofmap_dim_t'(1);
            end
        end
    end

    // last column of a row, then last position of the layer
    assign row_flush  = (col_cnt == width_m1);
    assign layer_last = row_flush && (row_cnt == width_m1);

endmodule

`default_nettype wire

//--- conv_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module conv_control_unit #(
    parameter int MAC_NUM = cu_pkg::MAC_NUM_DEFAULT
) (
    input  wire logic               clk,
    input  wire logic               rst_n,
    input  wire cu_pkg::ctrl_word_t ctrl_0,
    input  wire cu_pkg::ctrl_word_t ctrl_1,
    input  wire cu_pkg::ctrl_word_t ctrl_2,
    input  wire logic               ifmap_fifo_empty,
    input  wire logic               weight_valid,
    output logic                    layer_finish,
    output logic [MAC_NUM-1:0]      mac_enable,
    output cu_pkg::op_t             operation,
    output cu_pkg::kernel_t         kernel_size,
    output cu_pkg::chan_cnt_t       in_channels,
    output cu_pkg::chan_cnt_t       out_channels,
    output logic                    load_ifmaps,
    output logic                    load_weight_preload,
    output logic                    load_weight,
    output logic                    bram_port_sel,
    output logic                    bram_transfer_start
);

    logic compute_phase;
    logic loader_idle;
    logic round_done;
    logic row_flush;
    logic layer_last;

    cu_cfg_if cfg ();

    instr_decoder #(
        .MAC_NUM (MAC_NUM)
    ) u_decoder (
        .ctrl_0      (ctrl_0),
        .ctrl_1      (ctrl_1),
        .ctrl_2      (ctrl_2),
        .cfg         (cfg.src),
        .in_channels (in_channels),
        .operation   (operation),
        .mac_enable  (mac_enable)
    );

    ifmap_loader u_loader (
        .clk              (clk),
        .rst_n            (rst_n),
        .cfg              (cfg.dst),
        .ifmap_fifo_empty (ifmap_fifo_empty),
        .round_done       (round_done),
        .row_flush        (row_flush),
        .layer_last       (layer_last),
        .load_ifmaps      (load_ifmaps),
        .compute_phase    (compute_phase),
        .loader_idle      (loader_idle)
    );

    weight_sequencer u_weights (
        .clk                 (clk),
        .rst_n               (rst_n),
        .cfg                 (cfg.dst),
        .compute_phase       (compute_phase),
        .weight_valid        (weight_valid),
        .load_weight_preload (load_weight_preload),
        .load_weight         (load_weight),
        .bram_port_sel       (bram_port_sel),
        .bram_transfer_start (bram_transfer_start),
        .round_done          (round_done)
    );

    ofmap_tracker u_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .cfg         (cfg.dst),
        .loader_idle (loader_idle),
        .round_done  (round_done),
        .row_flush   (row_flush),
        .layer_last  (layer_last)
    );

    // last weight load of the last output position
    assign layer_finish = round_done & layer_last;

    assign kernel_size  = cfg.kernel_size;
    assign out_channels = cfg.out_channels;

endmodule

`default_nettype wire

//--- tb_conv_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_conv_control_unit;

    localparam int         MAC_NUM        = 16;
    localparam int         NUM_TESTS      = 6;
    localparam int         IDLE_CYCLES    = 3;
    localparam int         QUIET_WINDOW   = 20;
    localparam logic [7:0] OPCODE_COMPUTE = 8'd87;
    localparam logic [7:0] OPCODE_OTHER   = 8'h33;

    // one row per test across these columns:
    // opcode present, kernel size, out channels, width, in channels, op
    int tab_opc [NUM_TESTS] = '{1, 0, 1, 1, 1, 1};
    int tab_k   [NUM_TESTS] = '{3, 2, 1, 5, 2, 4};
    int tab_oc  [NUM_TESTS] = '{4, 3, 2, 3, 1, 5};
    int tab_w   [NUM_TESTS] = '{3, 2, 4, 2, 1, 3};
    int tab_ic  [NUM_TESTS] = '{5, 9, 16, 20, 0, 12};
    int tab_op  [NUM_TESTS] = '{1, 2, 0, 3, 1, 2};

    logic               clk              = 1'b0;
    logic               rst_n            = 1'b0;
    // compute request already present while reset is held
    logic [31:0]        ctrl_0           = {24'd0, OPCODE_COMPUTE};
    logic [31:0]        ctrl_1           = '0;
    logic [31:0]        ctrl_2           = '0;
    logic               ifmap_fifo_empty = 1'b1;
    logic               weight_valid     = 1'b0;
    logic               layer_finish;
    logic [MAC_NUM-1:0] mac_enable;
    logic [1:0]         operation;
    logic [4:0]         kernel_size;
    logic [11:0]        in_channels;
    logic [11:0]        out_channels;
    logic               load_ifmaps;
    logic               load_weight_preload;
    logic               load_weight;
    logic               bram_port_sel;
    logic               bram_transfer_start;

    logic [31:0] lfsr         = 32'h5661_1134;
    logic        prev_empty   = 1'b1;
    int          cycle_cnt    = 0;
    int          cycle_limit  = 0;
    int          error_cnt    = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          cnt_lw;
    int          cnt_pre;
    int          cnt_ifm;
    int          cnt_bts;
    int          cnt_sel;
    int          cnt_fin;

    conv_control_unit #(
        .MAC_NUM (MAC_NUM)
    ) uut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .ctrl_0              (ctrl_0),
        .ctrl_1              (ctrl_1),
        .ctrl_2              (ctrl_2),
        .ifmap_fifo_empty    (ifmap_fifo_empty),
        .weight_valid        (weight_valid),
        .layer_finish        (layer_finish),
        .mac_enable          (mac_enable),
        .operation           (operation),
        .kernel_size         (kernel_size),
        .in_channels         (in_channels),
        .out_channels        (out_channels),
        .load_ifmaps         (load_ifmaps),
        .load_weight_preload (load_weight_preload),
        .load_weight         (load_weight),
        .bram_port_sel       (bram_port_sel),
        .bram_transfer_start (bram_transfer_start)
    );

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // random handshakes
    //////////////////////////////////////////////////

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    always @(posedge clk) begin
        lfsr = lfsr_next(lfsr);
        ifmap_fifo_empty <= lfsr[0];
        lfsr = lfsr_next(lfsr);
        weight_valid <= lfsr[0];
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // checking helpers
    //////////////////////////////////////////////////

    function automatic logic outputs_quiet();
        return !(layer_finish | load_ifmaps | load_weight_preload | load_weight
                 | bram_port_sel | bram_transfer_start);
    endfunction

    // lowest ic lanes enabled, every lane from MAC_NUM channels up
    function automatic logic [MAC_NUM-1:0] lane_mask(input int ic);
        if (ic >= MAC_NUM) begin
            return '1;
        end
        return MAC_NUM'((32'(1) << ic) - 32'(1));
    endfunction

    task automatic check_quiet(input string where);
        if (!outputs_quiet()) begin
            $display("FAIL %0t: control output active %s", $time, where);
            error_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %0t: %s count %0d, expected %0d", $time, name, got, exp);
            error_cnt++;
        end
    endtask

    // sample at negedge, where the outputs are settled
    task automatic sample_cycle();
        @(negedge clk);
        if (load_ifmaps && prev_empty) begin
            $display("FAIL %0t: load_ifmaps after an edge with the fifo empty", $time);
            error_cnt++;
        end
        cnt_lw     += int'(load_weight);
        cnt_pre    += int'(load_weight_preload);
        cnt_ifm    += int'(load_ifmaps);
        cnt_bts    += int'(bram_transfer_start);
        cnt_sel    += int'(bram_port_sel);
        cnt_fin    += int'(layer_finish);
        prev_empty  = ifmap_fifo_empty;
    endtask

    task automatic run_test(input int t);
        int         k;
        int         oc;
        int         w;
        int         ic;
        int         op;
        int         err_start;
        int         exp_lw;
        logic [7:0] opc;
        logic [4:0] exp_kern;
        k         = tab_k[t];
        oc        = tab_oc[t];
        w         = tab_w[t];
        ic        = tab_ic[t];
        op        = tab_op[t];
        err_start = error_cnt;
        opc       = (tab_opc[t] != 0) ? OPCODE_COMPUTE : OPCODE_OTHER;
        exp_kern  = 5'(32'(1) << (k - 1));
        exp_lw    = (tab_opc[t] != 0) ? oc * w * w : 0;
        cnt_lw    = 0;
        cnt_pre   = 0;
        cnt_ifm   = 0;
        cnt_bts   = 0;
        cnt_sel   = 0;
        cnt_fin   = 0;

        @(posedge clk);
        ctrl_0 <= {oc[11:0], ic[11:0], opc};
        ctrl_1 <= {21'd0, w[8:0], op[1:0]};
        ctrl_2 <= {27'd0, exp_kern};

        if (tab_opc[t] != 0) begin
            while (cnt_fin == 0) begin
                sample_cycle();
            end
        end else begin
            repeat (QUIET_WINDOW) begin
                sample_cycle();
                check_quiet("without the compute opcode");
            end
        end

        // decoder echoes
        if (mac_enable != lane_mask(ic) || kernel_size != exp_kern || operation != op[1:0]
            || in_channels != ic[11:0] || out_channels != oc[11:0]) begin
            $display("FAIL %0t: decoded fields mac=%h k=%b op=%0d ic=%0d oc=%0d", $time,
                     mac_enable, kernel_size, operation, in_channels, out_channels);
            error_cnt++;
        end
        check_count("load_weight", cnt_lw, exp_lw);
        check_count("load_weight_preload", cnt_pre, k * exp_lw);
        check_count("load_ifmaps", cnt_ifm, (tab_opc[t] != 0) ? w * (k + w - 1) : 0);
        check_count("bram_transfer_start", cnt_bts, (tab_opc[t] != 0) ? w * w : 0);
        // steps alternate starting with a memory read, k/2 of them use the other port
        check_count("bram_port_sel", cnt_sel, (k / 2) * exp_lw);
        check_count("layer_finish", cnt_fin, (tab_opc[t] != 0) ? 1 : 0);

        // host drops the opcode
        @(posedge clk);
        ctrl_0 <= 32'h0;
        repeat (IDLE_CYCLES) begin
            sample_cycle();
            check_quiet("after the opcode was dropped");
        end

        if (error_cnt == err_start) begin
            tests_passed++;
            $display("test %0d ok: k=%0d oc=%0d w=%0d ic=%0d, %0d weight loads",
                     t, k, oc, w, ic, cnt_lw);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d errors", t, error_cnt - err_start);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int work;
        work = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            work += tab_w[t] * tab_w[t] * tab_oc[t] * (tab_k[t] + 1);
        end
        cycle_limit = 40 * work + 50 * NUM_TESTS;

        // reset held for two cycles
        repeat (2) begin
            @(negedge clk);
            check_quiet("during reset");
        end
        @(posedge clk);
        rst_n  <= 1'b1;
        ctrl_0 <= '0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end

        $display("tests: %0d passed, %0d failed, %0d errors",
                 tests_passed, tests_failed, error_cnt);
        if (error_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
cu_pkg.sv
cu_cfg_if.sv
instr_decoder.sv
ifmap_loader.sv
weight_sequencer.sv
ofmap_tracker.sv
conv_control_unit.sv
tb_conv_control_unit.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module tb_conv_control_unit -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

# exit status follows the pass line
echo "$out" | grep -qF '*** PASSED ***'
